// File: include/tcdm_defines.svh
/* width, depth, memory size and execute latency macros */
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// initiator interface fields
`define TCDM_AW 16 // byte address bits
`define TCDM_DW 32 // data word bits
`define TCDM_BW 8  // bits per byte-enable lane
`define TCDM_IW 4  // transaction id bits

// queue and buffer sizing
`define TCDM_FIFO_DEPTH 4 // entries per outstanding queue
`define TCDM_RESP_SLOTS 4 // result buffer entries

// memory array
`define TCDM_MEM_WORDS 256 // words, not bytes

// ex_valid to rs_valid, in cycles
`define TCDM_EX_LATENCY 2

`endif

// File: design/hci_pkg.sv
/* initiator-side field types, packed request and response queue words */
`include "tcdm_defines.svh"

package hci_pkg;

  localparam int unsigned HCI_BEW = `TCDM_DW / `TCDM_BW; // byte-enable lanes

  typedef logic [`TCDM_AW-1:0] hci_addr_t; // byte address
  typedef logic [`TCDM_DW-1:0] hci_data_t;
  typedef logic [HCI_BEW-1:0]  hci_be_t;   // one bit per byte lane
  typedef logic [`TCDM_IW-1:0] hci_id_t;

  // add + id + data + be + wen
  localparam int unsigned HCI_REQ_W  = `TCDM_AW + `TCDM_IW + `TCDM_DW + HCI_BEW + 1;
  // id + err + data
  localparam int unsigned HCI_RESP_W = `TCDM_IW + 1 + `TCDM_DW;

  typedef logic [HCI_REQ_W-1:0]  hci_req_word_t;  // {add, id, data, be, wen}
  typedef logic [HCI_RESP_W-1:0] hci_resp_word_t; // {id, err, data}

endpackage

// File: design/tcdm_mem_pkg.sv
/* memory-side types: word index and result buffer occupancy */
`include "tcdm_defines.svh"

package tcdm_mem_pkg;

  localparam int unsigned MEM_IDX_W  = $clog2(`TCDM_MEM_WORDS);
  // must reach TCDM_RESP_SLOTS itself, hence the +1
  localparam int unsigned RESP_CNT_W = $clog2(`TCDM_RESP_SLOTS + 1);

  typedef logic [MEM_IDX_W-1:0]  mem_index_t;  // word index into the array
  typedef logic [RESP_CNT_W-1:0] resp_count_t; // buffered + in-flight responses

endpackage

// File: design/hci_fifo.sv
/* flop-based circular FIFO with valid/ready on both sides, clear, empty and full */
`timescale 1ns/1ps

module hci_fifo #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clear_i,
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  logic [DATA_WIDTH-1:0] push_data_i,
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output logic [DATA_WIDTH-1:0] pop_data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  localparam int unsigned PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH]; // payload, no reset
  logic [PW-1:0]         wr_ptr_q, rd_ptr_q;
  logic [CW-1:0]         cnt_q;              // fill level
  logic                  push_fire, pop_fire;

  // wrap explicitly so non power-of-two depths work
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    ptr_next = (p == PW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty_o      = (cnt_q == '0);
  assign full_o       = (cnt_q == CW'(FIFO_DEPTH));
  assign push_ready_o = ~full_o;
  assign pop_valid_o  = ~empty_o;  // no fall-through, data is one cycle behind push
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_fire) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_fire) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push_fire != pop_fire) cnt_q <= push_fire ? cnt_q + 1'b1 : cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) mem_q[wr_ptr_q] <= push_data_i; // stale write on clear is harmless
  end

  // fill level stays within depth, pointers meet only when empty or full
  ap_no_overflow : assert property (@(posedge clk_i) disable iff (reset_i)
    cnt_q <= CW'(FIFO_DEPTH));
  ap_no_underflow : assert property (@(posedge clk_i) disable iff (reset_i)
    (wr_ptr_q == rd_ptr_q) == (empty_o || full_o));

endmodule

// File: design/hci_outstanding_fifo.sv
/* outstanding buffer: request queue toward memory, response queue back to the initiator */
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module hci_outstanding_fifo #(
  parameter int unsigned FIFO_DEPTH = `TCDM_FIFO_DEPTH
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               clear_i,
  // target side, facing the accelerator
  input  logic               tgt_req_valid_i,
  output logic               tgt_req_ready_o,
  input  hci_pkg::hci_addr_t tgt_req_add_i,
  input  logic               tgt_req_wen_i,  // 1 read, 0 write
  input  hci_pkg::hci_be_t   tgt_req_be_i,
  input  hci_pkg::hci_data_t tgt_req_data_i,
  input  hci_pkg::hci_id_t   tgt_req_id_i,
  output logic               tgt_resp_valid_o,
  input  logic               tgt_resp_ready_i,
  output hci_pkg::hci_data_t tgt_resp_data_o,
  output hci_pkg::hci_id_t   tgt_resp_id_o,
  output logic               tgt_resp_err_o,
  // initiator side, facing the memory path
  output logic               ini_req_valid_o,
  input  logic               ini_req_ready_i,
  output hci_pkg::hci_addr_t ini_req_add_o,
  output logic               ini_req_wen_o,
  output hci_pkg::hci_be_t   ini_req_be_o,
  output hci_pkg::hci_data_t ini_req_data_o,
  output hci_pkg::hci_id_t   ini_req_id_o,
  input  logic               ini_resp_valid_i,
  output logic               ini_resp_ready_o,
  input  hci_pkg::hci_data_t ini_resp_data_i,
  input  hci_pkg::hci_id_t   ini_resp_id_i,
  input  logic               ini_resp_err_i,
  output logic               empty_o,
  output logic               full_o
);

  import hci_pkg::*;

  hci_req_word_t  req_push_word, req_pop_word;
  hci_resp_word_t resp_push_word, resp_pop_word;
  logic           req_empty, req_full, resp_empty, resp_full;

  // same field order as the target request bundle
  assign req_push_word = {tgt_req_add_i, tgt_req_id_i, tgt_req_data_i, tgt_req_be_i, tgt_req_wen_i};
  assign {ini_req_add_o, ini_req_id_o, ini_req_data_o, ini_req_be_o, ini_req_wen_o} = req_pop_word;

  assign resp_push_word = {ini_resp_id_i, ini_resp_err_i, ini_resp_data_i};
  assign {tgt_resp_id_o, tgt_resp_err_o, tgt_resp_data_o} = resp_pop_word;

  hci_fifo #(
    .DATA_WIDTH ($bits(hci_req_word_t)),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .clear_i      (clear_i),
    .push_valid_i (tgt_req_valid_i),
    .push_ready_o (tgt_req_ready_o), // low while full
    .push_data_i  (req_push_word),
    .pop_valid_o  (ini_req_valid_o),
    .pop_ready_i  (ini_req_ready_i),
    .pop_data_o   (req_pop_word),
    .empty_o      (req_empty),
    .full_o       (req_full)
  );

  hci_fifo #(
    .DATA_WIDTH ($bits(hci_resp_word_t)),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_resp_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .clear_i      (clear_i),
    .push_valid_i (ini_resp_valid_i),
    .push_ready_o (ini_resp_ready_o),
    .push_data_i  (resp_push_word),
    .pop_valid_o  (tgt_resp_valid_o),
    .pop_ready_i  (tgt_resp_ready_i),
    .pop_data_o   (resp_pop_word),
    .empty_o      (resp_empty),
    .full_o       (resp_full)
  );

  assign empty_o = req_empty & resp_empty; // idle only when both drained
  assign full_o  = req_full | resp_full;

endmodule

// File: design/tcdm_addr_decode.sv
/* decode stage: one register, byte address to word index, range check */
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_addr_decode (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     clear_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  hci_pkg::hci_addr_t       req_add_i,
  input  logic                     req_wen_i,
  input  hci_pkg::hci_be_t         req_be_i,
  input  hci_pkg::hci_data_t       req_data_i,
  input  hci_pkg::hci_id_t         req_id_i,
  input  logic                     space_i,    // result stage has a free reservation
  output logic                     ex_valid_o,
  output tcdm_mem_pkg::mem_index_t ex_index_o,
  output logic                     ex_err_o,
  output logic                     ex_wen_o,
  output hci_pkg::hci_be_t         ex_be_o,
  output hci_pkg::hci_data_t       ex_data_o,
  output hci_pkg::hci_id_t         ex_id_o
);

  import hci_pkg::*;
  import tcdm_mem_pkg::*;

  localparam int unsigned WAW = $bits(hci_addr_t) - 2; // word address bits

  logic [WAW-1:0] word_addr;
  mem_index_t     word_index;
  logic           out_of_range;
  logic           accept;

  // execute has no ready, so the register empties every cycle and only space stalls
  assign req_ready_o  = space_i;
  assign accept       = req_valid_i & req_ready_o;
  assign word_addr    = req_add_i[$bits(hci_addr_t)-1:2]; // drop byte offset
  assign word_index   = mem_index_t'(word_addr);
  assign out_of_range = 32'(word_addr) >= 32'(`TCDM_MEM_WORDS);

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) ex_valid_o <= 1'b0;
    else ex_valid_o <= accept; // issue one cycle after acceptance
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ex_index_o <= word_index;
      ex_err_o   <= out_of_range;
      ex_wen_o   <= req_wen_i;
      ex_be_o    <= req_be_i;
      ex_data_o  <= req_data_i;
      ex_id_o    <= req_id_i;
    end
  end

endmodule

// File: design/tcdm_bank_exec.sv
/* execute stage: memory array, byte-enable writes, fixed two-stage read pipeline */
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_bank_exec (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     clear_i,
  input  logic                     ex_valid_i,
  input  tcdm_mem_pkg::mem_index_t ex_index_i,
  input  logic                     ex_err_i,
  input  logic                     ex_wen_i,
  input  hci_pkg::hci_be_t         ex_be_i,
  input  hci_pkg::hci_data_t       ex_data_i,
  input  hci_pkg::hci_id_t         ex_id_i,
  output logic                     rs_valid_o,
  output hci_pkg::hci_id_t         rs_id_o,
  output logic                     rs_err_o,
  output hci_pkg::hci_data_t       rs_data_o
);

  import hci_pkg::*;

  hci_data_t mem_q [`TCDM_MEM_WORDS];
  hci_data_t rdata_q;       // stage 1 read word
  hci_id_t   id_q;
  logic      valid_q, err_q, wen_q;
  logic      do_write;

  // out-of-range and cleared accesses leave the array alone
  assign do_write = ex_valid_i & ~ex_wen_i & ~ex_err_i & ~clear_i;

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int b = 0; b < $bits(hci_be_t); b++) begin
        if (ex_be_i[b]) mem_q[ex_index_i][b*`TCDM_BW +: `TCDM_BW] <= ex_data_i[b*`TCDM_BW +: `TCDM_BW];
      end
    end
  end

  // valids of both stages, so two requests can be in flight
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      valid_q    <= 1'b0;
      rs_valid_o <= 1'b0;
    end else begin
      valid_q    <= ex_valid_i;
      rs_valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      rdata_q <= mem_q[ex_index_i]; // old word on a write, never returned
      id_q    <= ex_id_i;
      err_q   <= ex_err_i;
      wen_q   <= ex_wen_i;
    end
    if (valid_q) begin
      rs_id_o   <= id_q;
      rs_err_o  <= err_q;
      rs_data_o <= (wen_q && !err_q) ? rdata_q : '0; // writes and errors give zero
    end
  end

  // every issue not killed by clear comes back after the fixed latency
  ap_fixed_latency : assert property (@(posedge clk_i) disable iff (reset_i)
    (ex_valid_i && !clear_i) ##1 (!clear_i) [* (`TCDM_EX_LATENCY - 1)] |=> rs_valid_o);

endmodule

// File: design/tcdm_resp_return.sv
/* result stage: response buffer, reservation count and space signal for decode */
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_resp_return (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               clear_i,
  input  logic               issue_i,    // decode ex_valid
  input  logic               rs_valid_i,
  input  hci_pkg::hci_id_t   rs_id_i,
  input  logic               rs_err_i,
  input  hci_pkg::hci_data_t rs_data_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output hci_pkg::hci_id_t   out_id_o,
  output logic               out_err_o,
  output hci_pkg::hci_data_t out_data_o,
  output logic               space_o
);

  import hci_pkg::*;
  import tcdm_mem_pkg::*;

  localparam int unsigned SLOTS = `TCDM_RESP_SLOTS;
  localparam int unsigned SW    = (SLOTS > 1) ? $clog2(SLOTS) : 1;

  hci_id_t     buf_id_q   [SLOTS];
  logic        buf_err_q  [SLOTS];
  hci_data_t   buf_data_q [SLOTS];
  logic [SW-1:0] wr_q, rd_q;
  resp_count_t cnt_q;  // entries held in the buffer
  resp_count_t rsv_q;  // buffered plus in flight through execute
  logic        buf_full, pop;

  assign buf_full    = (cnt_q == resp_count_t'(SLOTS));
  assign out_valid_o = (cnt_q != '0); // offered the cycle after entry
  assign out_id_o    = buf_id_q[rd_q];
  assign out_err_o   = buf_err_q[rd_q];
  assign out_data_o  = buf_data_q[rd_q];
  assign pop         = out_valid_o & out_ready_i;

  // issue_i is counted here already since rsv_q only picks it up next edge
  assign space_o = (32'(rsv_q) + 32'(issue_i)) < SLOTS;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      wr_q  <= '0;
      rd_q  <= '0;
      cnt_q <= '0;
      rsv_q <= '0;
    end else begin
      if (rs_valid_i) wr_q <= (wr_q == SW'(SLOTS - 1)) ? '0 : wr_q + 1'b1;
      if (pop) rd_q <= (rd_q == SW'(SLOTS - 1)) ? '0 : rd_q + 1'b1;
      if (rs_valid_i != pop) cnt_q <= rs_valid_i ? cnt_q + 1'b1 : cnt_q - 1'b1;
      if (issue_i != pop) rsv_q <= issue_i ? rsv_q + 1'b1 : rsv_q - 1'b1; // freed on pop only
    end
  end

  always_ff @(posedge clk_i) begin
    if (rs_valid_i) begin
      buf_id_q[wr_q]   <= rs_id_i;
      buf_err_q[wr_q]  <= rs_err_i;
      buf_data_q[wr_q] <= rs_data_i;
    end
  end

  // the reservation made at decode must guarantee room when execute delivers
  ap_rsv_room : assert property (@(posedge clk_i) disable iff (reset_i)
    rs_valid_i |-> !buf_full);

endmodule

// File: design/tcdm_subsystem_top.sv
/* top level: outstanding FIFO, decode, execute and result stages */
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_subsystem_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               clear_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  hci_pkg::hci_addr_t req_add_i,
  input  logic               req_wen_i,
  input  hci_pkg::hci_be_t   req_be_i,
  input  hci_pkg::hci_data_t req_data_i,
  input  hci_pkg::hci_id_t   req_id_i,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output hci_pkg::hci_data_t resp_data_o,
  output hci_pkg::hci_id_t   resp_id_o,
  output logic               resp_err_o,
  output logic               flags_empty_o,
  output logic               flags_full_o
);

  import hci_pkg::*;
  import tcdm_mem_pkg::*;

  // request queue to decode
  logic       dec_req_valid, dec_req_ready, dec_req_wen;
  hci_addr_t  dec_req_add;
  hci_be_t    dec_req_be;
  hci_data_t  dec_req_data;
  hci_id_t    dec_req_id;
  // decode to execute
  logic       ex_valid, ex_err, ex_wen;
  mem_index_t ex_index;
  hci_be_t    ex_be;
  hci_data_t  ex_data;
  hci_id_t    ex_id;
  // execute to result, result to response queue
  logic       rs_valid, rs_err, rb_valid, rb_ready, rb_err, rsv_space;
  hci_id_t    rs_id, rb_id;
  hci_data_t  rs_data, rb_data;

  hci_outstanding_fifo #(
    .FIFO_DEPTH (`TCDM_FIFO_DEPTH)
  ) i_outstanding (
    .clk_i (clk_i), .reset_i (reset_i), .clear_i (clear_i),
    .tgt_req_valid_i (req_valid_i), .tgt_req_ready_o (req_ready_o),
    .tgt_req_add_i (req_add_i), .tgt_req_wen_i (req_wen_i), .tgt_req_be_i (req_be_i),
    .tgt_req_data_i (req_data_i), .tgt_req_id_i (req_id_i),
    .tgt_resp_valid_o (resp_valid_o), .tgt_resp_ready_i (resp_ready_i),
    .tgt_resp_data_o (resp_data_o), .tgt_resp_id_o (resp_id_o), .tgt_resp_err_o (resp_err_o),
    .ini_req_valid_o (dec_req_valid), .ini_req_ready_i (dec_req_ready),
    .ini_req_add_o (dec_req_add), .ini_req_wen_o (dec_req_wen), .ini_req_be_o (dec_req_be),
    .ini_req_data_o (dec_req_data), .ini_req_id_o (dec_req_id),
    .ini_resp_valid_i (rb_valid), .ini_resp_ready_o (rb_ready),
    .ini_resp_data_i (rb_data), .ini_resp_id_i (rb_id), .ini_resp_err_i (rb_err),
    .empty_o (flags_empty_o), .full_o (flags_full_o)
  );

  tcdm_addr_decode i_decode (
    .clk_i (clk_i), .reset_i (reset_i), .clear_i (clear_i),
    .req_valid_i (dec_req_valid), .req_ready_o (dec_req_ready),
    .req_add_i (dec_req_add), .req_wen_i (dec_req_wen), .req_be_i (dec_req_be),
    .req_data_i (dec_req_data), .req_id_i (dec_req_id),
    .space_i (rsv_space),
    .ex_valid_o (ex_valid), .ex_index_o (ex_index), .ex_err_o (ex_err), .ex_wen_o (ex_wen),
    .ex_be_o (ex_be), .ex_data_o (ex_data), .ex_id_o (ex_id)
  );

  tcdm_bank_exec i_exec (
    .clk_i (clk_i), .reset_i (reset_i), .clear_i (clear_i),
    .ex_valid_i (ex_valid), .ex_index_i (ex_index), .ex_err_i (ex_err), .ex_wen_i (ex_wen),
    .ex_be_i (ex_be), .ex_data_i (ex_data), .ex_id_i (ex_id),
    .rs_valid_o (rs_valid), .rs_id_o (rs_id), .rs_err_o (rs_err), .rs_data_o (rs_data)
  );

  tcdm_resp_return i_result (
    .clk_i (clk_i), .reset_i (reset_i), .clear_i (clear_i),
    .issue_i (ex_valid),
    .rs_valid_i (rs_valid), .rs_id_i (rs_id), .rs_err_i (rs_err), .rs_data_i (rs_data),
    .out_valid_o (rb_valid), .out_ready_i (rb_ready),
    .out_id_o (rb_id), .out_err_o (rb_err), .out_data_o (rb_data),
    .space_o (rsv_space)
  );

endmodule

// File: testbench/tb_tcdm_subsystem.sv
/* testbench for the TCDM subsystem: request stimulus, reference memory,
   expected-response queue, concurrent checks and watchdog */
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tb_tcdm_subsystem;

  import hci_pkg::*;

  // init + partial pairs + random + errors + readback + back-pressure + clear + post-clear
  localparam int N_TXN = 256 + 64 + 64 + 8 + 256 + 40 + 6 + 8;

  typedef logic [`TCDM_IW+`TCDM_DW:0] resp_entry_t; // {id, err, data}

  logic clk_i = 1'b0;
  logic reset_i, clear_i, req_valid_i, req_wen_i;
  logic resp_ready_i = 1'b1; // owned by the ready driver below
  hci_addr_t req_add_i;
  hci_be_t   req_be_i;
  hci_data_t req_data_i;
  hci_id_t   req_id_i;
  logic      req_ready_o, resp_valid_o, resp_err_o, flags_empty_o, flags_full_o;
  hci_data_t resp_data_o;
  hci_id_t   resp_id_o;

  hci_data_t   ref_mem [`TCDM_MEM_WORDS]; // reference memory
  resp_entry_t exp_q [$];                 // expected responses in issue order
  logic        exp_avail = 1'b0;
  hci_id_t     exp_id;
  logic        exp_err;
  hci_data_t   exp_data;
  bit          any_req_seen = 1'b0;
  bit          stall_pat [256];           // random resp_ready_i pattern
  int          ready_mode = 0;            // 0 ready, 1 random stalls, 2 held low
  int unsigned cyc = 0;

  tcdm_subsystem_top uut (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got, input logic [63:0] exp);
    abort_run($sformatf("FAIL %s = 0x%0h, expected 0x%0h", sig, got, exp));
  endtask

  always @(negedge clk_i) begin
    cyc = cyc + 1;
    case (ready_mode)
      0:       resp_ready_i = 1'b1;
      1:       resp_ready_i = !stall_pat[cyc % 256];
      default: resp_ready_i = 1'b0;
    endcase
  end

  // model: push at request handshake, pop at response handshake, flush on clear
  always @(posedge clk_i) begin : model
    int unsigned word;
    if (reset_i || clear_i) exp_q.delete();
    else begin
      if (resp_valid_o && resp_ready_i && exp_q.size() > 0) void'(exp_q.pop_front());
      if (req_valid_i && req_ready_o) begin
        any_req_seen = 1'b1;
        word = req_add_i >> 2;               // byte offset dropped
        if (word >= `TCDM_MEM_WORDS) exp_q.push_back({req_id_i, 1'b1, 32'h0});
        else if (req_wen_i) exp_q.push_back({req_id_i, 1'b0, ref_mem[word]});
        else begin
          for (int b = 0; b < HCI_BEW; b++)
            if (req_be_i[b]) ref_mem[word][b*`TCDM_BW +: `TCDM_BW] = req_data_i[b*`TCDM_BW +: `TCDM_BW];
          exp_q.push_back({req_id_i, 1'b0, 32'h0}); // writes answer with zero
        end
      end
    end
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) {exp_id, exp_err, exp_data} = exp_q[0];
  end

  // idle outputs until the first request
  a_idle_valid : assert property (@(posedge clk_i) disable iff (reset_i)
    !any_req_seen |-> !resp_valid_o) else report_mismatch("resp_valid_o", $sampled(resp_valid_o), 0);
  a_idle_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    !any_req_seen |-> flags_empty_o) else report_mismatch("flags_empty_o", $sampled(flags_empty_o), 1);
  a_idle_full : assert property (@(posedge clk_i) disable iff (reset_i)
    !any_req_seen |-> !flags_full_o) else report_mismatch("flags_full_o", $sampled(flags_full_o), 0);
  // catches stale responses after clear and duplicates
  a_no_stale : assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o |-> exp_avail) else abort_run("response offered with no request outstanding");
  a_resp_id : assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && resp_ready_i && exp_avail |-> resp_id_o == exp_id)
    else report_mismatch("resp_id_o", $sampled(resp_id_o), $sampled(exp_id));
  a_resp_err : assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && resp_ready_i && exp_avail |-> resp_err_o == exp_err)
    else report_mismatch("resp_err_o", $sampled(resp_err_o), $sampled(exp_err));
  a_resp_data : assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && resp_ready_i && exp_avail |-> resp_data_o == exp_data)
    else report_mismatch("resp_data_o", $sampled(resp_data_o), $sampled(exp_data));
  a_full_flag : assert property (@(posedge clk_i) disable iff (reset_i)
    !req_ready_o |-> flags_full_o) else report_mismatch("flags_full_o", $sampled(flags_full_o), 1);
  a_clear_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    clear_i |=> flags_empty_o) else report_mismatch("flags_empty_o", $sampled(flags_empty_o), 1);

  // waits for the handshake of the pending request, returns at a falling edge
  // on a timeout the request stays pending with valid and payload unchanged
  task automatic wait_accept(input int max_wait, output bit ok);
    int n;
    n = 0;
    while (!req_ready_o && n < max_wait) begin
      @(negedge clk_i);
      n++;
    end
    ok = req_ready_o;
    if (ok) begin
      @(negedge clk_i); // handshake on the rising edge in between
      req_valid_i = 1'b0;
    end
  endtask

  // called at a falling edge, returns at a falling edge
  task automatic send_req(input hci_addr_t add, input logic wen, input hci_be_t be,
                          input hci_data_t data, input int max_wait, output bit ok);
    req_valid_i = 1'b1;
    req_add_i   = add;
    req_wen_i   = wen;
    req_be_i    = be;
    req_data_i  = data;
    req_id_i    = hci_id_t'($urandom);
    wait_accept(max_wait, ok);
  endtask

  task automatic issue(input hci_addr_t add, input logic wen, input hci_be_t be, input hci_data_t data);
    bit ok;
    send_req(add, wen, be, data, 2000, ok);
    if (!ok) abort_run("request was never accepted by the DUT");
  endtask

  task automatic set_ready_mode(input int m);
    @(posedge clk_i);
    ready_mode = m; // seen by the ready driver at the next falling edge
    @(negedge clk_i);
  endtask

  task automatic drain(input int limit, output bit done);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || !flags_empty_o) && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    done = (exp_q.size() == 0) && flags_empty_o;
  endtask

  initial begin : stimulus
    bit ok, stalled, done;
    hci_addr_t a;
    void'($urandom(32'hde64698f));
    for (int i = 0; i < 256; i++) stall_pat[i] = ($urandom % 4) == 0;
    reset_i = 1'b1;
    clear_i = 1'b0;
    req_valid_i = 1'b0;
    req_wen_i = 1'b0;
    req_add_i = '0;
    req_be_i = '0;
    req_data_i = '0;
    req_id_i = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (4) @(negedge clk_i); // idle window for the reset checks

    for (int i = 0; i < `TCDM_MEM_WORDS; i++) issue(hci_addr_t'(i << 2), 1'b0, '1, $urandom);
    set_ready_mode(1);
    for (int i = 0; i < 32; i++) begin // partial write, then read back
      a = hci_addr_t'(($urandom % `TCDM_MEM_WORDS) << 2);
      issue(a, 1'b0, hci_be_t'($urandom), $urandom);
      issue(a, 1'b1, '0, '0);
    end
    for (int i = 0; i < 64; i++)        // mixed traffic, some beyond the array
      issue(hci_addr_t'($urandom % 16'h0480), $urandom % 2, hci_be_t'($urandom), $urandom);
    for (int i = 0; i < 8; i++)
      issue(hci_addr_t'(16'h0400 + $urandom % 16'hfc00), i % 2, '1, $urandom);
    for (int i = 0; i < `TCDM_MEM_WORDS; i++) issue(hci_addr_t'(i << 2), 1'b1, '0, '0);

    set_ready_mode(2);                  // hold responses back until the queue fills
    stalled = 1'b0;
    for (int i = 0; i < 40 && !stalled; i++) begin
      send_req(hci_addr_t'(($urandom % `TCDM_MEM_WORDS) << 2), 1'b1, '0, '0, 20, ok);
      stalled = !ok;
    end
    if (!stalled) abort_run("req_ready_o never fell while responses were held back");
    if (!flags_full_o) report_mismatch("flags_full_o", flags_full_o, 1);
    set_ready_mode(1);
    wait_accept(1000, ok);              // the held request goes in once the chain moves
    if (!ok) abort_run("held request was never accepted after responses were released");
    drain(1000, done);
    if (!done) report_mismatch("flags_empty_o", flags_empty_o, 1);

    set_ready_mode(2);                  // reads only, so clear leaves the array intact
    for (int i = 0; i < 6; i++) issue(hci_addr_t'(($urandom % `TCDM_MEM_WORDS) << 2), 1'b1, '0, '0);
    repeat (3) @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    set_ready_mode(0);
    repeat (20) @(negedge clk_i);
    for (int i = 0; i < 8; i++) issue(hci_addr_t'(($urandom % `TCDM_MEM_WORDS) << 2), 1'b1, '0, '0);

    drain(500, done);
    if (done) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("responses still outstanding at the end of the run");
    end
  end

  initial begin : watchdog
    repeat (N_TXN * 40 + 200) @(posedge clk_i);
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

// File: list.f
+incdir+include
design/hci_pkg.sv
design/tcdm_mem_pkg.sv
design/hci_fifo.sv
design/hci_outstanding_fifo.sv
design/tcdm_addr_decode.sv
design/tcdm_bank_exec.sv
design/tcdm_resp_return.sv
design/tcdm_subsystem_top.sv
testbench/tb_tcdm_subsystem.sv
